//--- src.f
verilog/regmgr_cfg_pkg.sv
verilog/regmgr_op_pkg.sv
verilog/regmgr_ctrl.sv
verilog/regmgr_datapath.sv
verilog/register_manager.sv
bench/register_manager_props.sv
bench/register_manager_tb.sv

//--- Makefile
# Verilator build for the register manager testbench

VERILATOR ?= verilator
TOP       ?= register_manager_tb
FLIST     ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= sim passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

$(BUILD_DIR)/V$(TOP): $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- bench/register_manager_tb.sv
`timescale 1ns/1ps

// directed tests for the register manager, with a memory model
module register_manager_tb;

  import regmgr_cfg_pkg::*;
  import regmgr_op_pkg::*;

  localparam int MAX_CYCLES = 3000;

  logic     clk;
  logic     rst;
  logic     cmd_valid;
  logic     cmd_ready;
  reg_op_t  cmd_op;
  reg_num_t cmd_reg_num;
  logic     cmd_is_ptr;
  step_t    cmd_step;
  word_t    cmd_data;
  addr_t    base_addr;
  logic     mem_req_valid;
  logic     mem_req_ready;
  logic     mem_req_write;
  addr_t    mem_req_addr;
  word_t    mem_req_data;
  logic     mem_rsp_valid;
  logic     mem_rsp_ready;
  word_t    mem_rsp_data;
  logic     done_valid;
  logic     done_ready;
  word_t    done_data;

  // memory model, 64 words, low address bits select
  word_t       mem [0:63];
  logic        req_pend;
  logic        rsp_pend;
  logic        rsp_busy;
  int          rsp_wait;
  word_t       rsp_word;
  addr_t       req_addr_s;
  logic        req_write_s;
  word_t       req_data_s;
  addr_t       last_req_addr;
  logic        stall_en;
  logic [31:0] mem_rng;
  logic [31:0] done_rng;
  logic [31:0] stim_rng;

  // reference register state from the command rules
  word_t ref_value;
  word_t ref_ptr;
  addr_t cur_base;

  int errors;
  int tests_run;
  int cycles;

  register_manager DUT (.*);

  bind register_manager register_manager_props u_props (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, the DUT stopped answering", cycles);
      $display("sim failed");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // grants, responses and write-back, all on the falling edge
  always @(negedge clk) begin
    if (rst) begin
      mem_req_ready = 1'b0;
      mem_rsp_valid = 1'b0;
      mem_rsp_data  = '0;
      req_pend      = 1'b0;
      rsp_pend      = 1'b0;
      rsp_busy      = 1'b0;
      rsp_wait      = 0;
    end else begin
      // handshakes seen last falling edge completed at the rising edge
      if (rsp_pend) begin
        rsp_busy      = 1'b0;
        mem_rsp_valid = 1'b0;
      end
      if (req_pend) begin
        last_req_addr = req_addr_s;
        if (req_write_s) begin
          mem[req_addr_s[5:0]] = req_data_s;
        end
        rsp_word = mem[req_addr_s[5:0]];
        rsp_busy = 1'b1;
        mem_rng  = lcg_next(mem_rng);
        rsp_wait = stall_en ? int'(mem_rng[17:16]) : 0;
      end
      if (rsp_busy && !mem_rsp_valid) begin
        if (rsp_wait == 0) begin
          mem_rsp_valid = 1'b1;
          mem_rsp_data  = rsp_word;
        end else begin
          rsp_wait--;
        end
      end
      mem_rng       = lcg_next(mem_rng);
      mem_req_ready = stall_en ? mem_rng[20] : 1'b1;
      req_pend      = mem_req_valid && mem_req_ready;
      if (req_pend) begin
        req_addr_s  = mem_req_addr;
        req_write_s = mem_req_write;
        req_data_s  = mem_req_data;
      end
      rsp_pend = mem_rsp_valid && mem_rsp_ready;
    end
  end

  task automatic compare_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic compare_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  // one command through the port, then wait for its result
  task automatic send(input reg_op_t op, input reg_num_t rn, input logic is_ptr,
                      input step_t st, input word_t data, output word_t got,
                      output int lat);
    @(negedge clk);
    cmd_valid   = 1'b1;
    cmd_op      = op;
    cmd_reg_num = rn;
    cmd_is_ptr  = is_ptr;
    cmd_step    = st;
    cmd_data    = data;
    base_addr   = cur_base;
    while (!cmd_ready) @(negedge clk);
    // transfer on the next rising edge
    @(negedge clk);
    cmd_valid = 1'b0;
    lat       = 0;
    done_rng   = lcg_next(done_rng);
    done_ready = stall_en ? done_rng[19] : 1'b1;
    while (!(done_valid && done_ready)) begin
      if (done_valid && cmd_ready) begin
        $display("cmd_ready went high while a result was held");
        errors++;
      end
      if (!done_valid) begin
        lat++;
      end
      @(negedge clk);
      done_rng   = lcg_next(done_rng);
      done_ready = stall_en ? done_rng[19] : 1'b1;
    end
    got = done_data;
    @(negedge clk);
    done_ready = 1'b0;
  endtask

  // predicts the outcome from the command rules and checks it
  task automatic run_cmd(input reg_op_t op, input reg_num_t rn, input logic is_ptr,
                         input step_t st, input word_t data);
    word_t exp_value;
    word_t exp_ptr;
    word_t wr_word;
    word_t got;
    addr_t exp_addr;
    int    lat;
    exp_value = ref_value;
    exp_ptr   = ref_ptr;
    wr_word   = '0;
    if (op == OP_READ_P || op == OP_WRITE_P) begin
      exp_addr = cur_base + addr_t'(ref_ptr);
    end else begin
      exp_addr = cur_base + addr_t'(rn);
    end
    case (op)
      OP_LOAD: exp_value = data;
      OP_READ: begin
        exp_value = mem[exp_addr[5:0]];
        exp_ptr   = exp_value;
      end
      OP_READ_P: exp_value = mem[exp_addr[5:0]];
      OP_WRITE: begin
        wr_word = is_ptr ? ref_ptr : ref_value;
        if (st == STEP_INC) begin
          wr_word = wr_word + 16'd1;
        end else if (st == STEP_DEC) begin
          wr_word = wr_word - 16'd1;
        end
      end
      default: wr_word = ref_value;
    endcase
    send(op, rn, is_ptr, st, data, got, lat);
    compare_word("done_data", got, exp_value);
    if (op == OP_LOAD && lat != 0) begin
      $display("done_valid did not rise one cycle after the load was accepted");
      errors++;
    end
    if (op != OP_LOAD) begin
      compare_addr("mem_req_addr", last_req_addr, exp_addr);
    end
    if (op == OP_WRITE || op == OP_WRITE_P) begin
      compare_word("mem", mem[exp_addr[5:0]], wr_word);
    end
    ref_value = exp_value;
    ref_ptr   = exp_ptr;
  endtask

  task automatic report_test(input string name, input int start_errs);
    tests_run++;
    if (errors == start_errs) begin
      $display("test %s done, no errors", name);
    end else begin
      $display("test %s done, %0d errors", name, errors - start_errs);
    end
  endtask

  task automatic test_load();
    int e;
    e = errors;
    run_cmd(OP_LOAD, 4'd0, 1'b0, STEP_NONE, 16'h1234);
    run_cmd(OP_LOAD, 4'd7, 1'b1, STEP_INC, 16'hbeef);
    report_test("load", e);
  endtask

  task automatic test_read();
    int e;
    e = errors;
    cur_base = 16'h0010;
    run_cmd(OP_READ, 4'd0, 1'b0, STEP_NONE, '0);
    run_cmd(OP_READ, 4'd3, 1'b0, STEP_NONE, '0);
    run_cmd(OP_READ, 4'd15, 1'b0, STEP_NONE, '0);
    // base near the top wraps past zero
    cur_base = 16'hfff8;
    run_cmd(OP_READ, 4'd12, 1'b0, STEP_NONE, '0);
    report_test("read", e);
  endtask

  task automatic test_read_ptr();
    int e;
    e = errors;
    cur_base = 16'h0020;
    run_cmd(OP_READ, 4'd2, 1'b0, STEP_NONE, '0);
    run_cmd(OP_READ_P, 4'd0, 1'b0, STEP_NONE, '0);
    report_test("read_ptr", e);
  endtask

  task automatic test_write();
    int e;
    e = errors;
    cur_base = 16'h0004;
    // pointer and value differ after read then load
    run_cmd(OP_READ, 4'd5, 1'b0, STEP_NONE, '0);
    run_cmd(OP_LOAD, 4'd0, 1'b0, STEP_NONE, 16'h4321);
    for (int p = 0; p < 2; p++) begin
      run_cmd(OP_WRITE, 4'd1, p[0], STEP_NONE, '0);
      run_cmd(OP_WRITE, 4'd2, p[0], STEP_INC, '0);
      run_cmd(OP_WRITE, 4'd3, p[0], STEP_DEC, '0);
    end
    // all ones plus one wraps to zero
    run_cmd(OP_LOAD, 4'd0, 1'b0, STEP_NONE, 16'hffff);
    run_cmd(OP_WRITE, 4'd9, 1'b0, STEP_INC, '0);
    run_cmd(OP_LOAD, 4'd0, 1'b0, STEP_NONE, 16'h0000);
    run_cmd(OP_WRITE, 4'd10, 1'b0, STEP_DEC, '0);
    report_test("write", e);
  endtask

  task automatic test_write_ptr();
    int e;
    e = errors;
    cur_base = 16'h0008;
    run_cmd(OP_READ, 4'd6, 1'b0, STEP_NONE, '0);
    run_cmd(OP_LOAD, 4'd0, 1'b0, STEP_NONE, 16'h7e57);
    run_cmd(OP_WRITE_P, 4'd0, 1'b0, STEP_INC, '0);
    report_test("write_ptr", e);
  endtask

  task automatic test_stalls();
    int      e;
    reg_op_t op;
    step_t   st;
    e = errors;
    stall_en = 1'b1;
    for (int i = 0; i < 24; i++) begin
      stim_rng = lcg_next(stim_rng);
      op       = reg_op_t'(int'(stim_rng[31:16]) % 5);
      st       = step_t'(int'(stim_rng[15:12]) % 3);
      cur_base = addr_t'(stim_rng[27:22]);
      stim_rng = lcg_next(stim_rng);
      run_cmd(op, stim_rng[23:20], stim_rng[25], st, stim_rng[31:16]);
    end
    stall_en = 1'b0;
    report_test("stalls", e);
  endtask

  initial begin
    errors      = 0;
    tests_run   = 0;
    cycles      = 0;
    mem_rng     = 32'd81;
    done_rng    = 32'd81;
    stim_rng    = 32'd81;
    stall_en    = 1'b0;
    ref_value   = '0;
    ref_ptr     = '0;
    cur_base    = '0;
    rst         = 1'b1;
    cmd_valid   = 1'b0;
    cmd_op      = OP_LOAD;
    cmd_reg_num = '0;
    cmd_is_ptr  = 1'b0;
    cmd_step    = STEP_NONE;
    cmd_data    = '0;
    base_addr   = '0;
    done_ready  = 1'b0;
    // memory side idle until the model takes over
    mem_req_ready = 1'b0;
    mem_rsp_valid = 1'b0;
    mem_rsp_data  = '0;
    last_req_addr = '0;
    // fill from the full index
    for (int i = 0; i < 64; i++) begin
      mem[i] = word_t'(16'h5a00 ^ (i * 16'h0137) ^ (i << 10));
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    test_load();
    test_read();
    test_read_ptr();
    test_write();
    test_write_ptr();
    test_stalls();
    $display("%0d tests run, %0d errors", tests_run, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- bench/register_manager_props.sv
`timescale 1ns/1ps

// handshake checks on the register manager top level
module register_manager_props (
  input logic                  clk,
  input logic                  rst,
  input logic                  cmd_ready,
  input logic                  mem_req_valid,
  input logic                  mem_req_ready,
  input logic                  mem_req_write,
  input regmgr_cfg_pkg::addr_t mem_req_addr,
  input regmgr_cfg_pkg::word_t mem_req_data,
  input logic                  mem_rsp_ready,
  input logic                  done_valid,
  input logic                  done_ready,
  input regmgr_cfg_pkg::word_t done_data
);

  // request payload frozen while the memory stalls
  a_req_stable: assert property (@(posedge clk) disable iff (rst)
    mem_req_valid && !mem_req_ready |=>
      mem_req_valid && $stable(mem_req_addr) && $stable(mem_req_data) &&
      $stable(mem_req_write))
    else $error("memory request changed while waiting for ready");

  // result held until taken
  a_done_hold: assert property (@(posedge clk) disable iff (rst)
    done_valid && !done_ready |=> done_valid && $stable(done_data))
    else $error("done result dropped or changed before done_ready");

  // one command in flight
  a_cmd_blocked: assert property (@(posedge clk) disable iff (rst)
    (done_valid || mem_req_valid) |-> !cmd_ready)
    else $error("cmd_ready high while a request or result is held");

  // reset values, one cycle after rst is seen
  a_reset_vals: assert property (@(posedge clk)
    rst |=> cmd_ready && !mem_req_valid && !mem_rsp_ready && !done_valid &&
      (done_data == '0))
    else $error("outputs not at reset values after reset");

endmodule

//--- verilog/register_manager.sv
`timescale 1ns/1ps

// register manager top
// controller sequences, datapath holds the registers
module register_manager (
  input  logic                        clk,
  input  logic                        rst,

  // command port
  input  logic                        cmd_valid,
  output logic                        cmd_ready,
  input  regmgr_op_pkg::reg_op_t      cmd_op,
  input  regmgr_cfg_pkg::reg_num_t    cmd_reg_num,
  input  logic                        cmd_is_ptr,
  input  regmgr_op_pkg::step_t        cmd_step,
  input  regmgr_cfg_pkg::word_t       cmd_data,
  input  regmgr_cfg_pkg::addr_t       base_addr,

  // memory request
  output logic                        mem_req_valid,
  input  logic                        mem_req_ready,
  output logic                        mem_req_write,
  output regmgr_cfg_pkg::addr_t       mem_req_addr,
  output regmgr_cfg_pkg::word_t       mem_req_data,

  // memory response
  input  logic                        mem_rsp_valid,
  output logic                        mem_rsp_ready,
  input  regmgr_cfg_pkg::word_t       mem_rsp_data,

  // done port
  output logic                        done_valid,
  input  logic                        done_ready,
  output regmgr_cfg_pkg::word_t       done_data
);

  // one-cycle strobes, controller to datapath
  logic cmd_fire;
  logic rsp_fire;

  regmgr_ctrl u_ctrl (
    .clk           (clk),
    .rst           (rst),
    .cmd_valid     (cmd_valid),
    .cmd_op        (cmd_op),
    .cmd_ready     (cmd_ready),
    .cmd_fire      (cmd_fire),
    .mem_req_valid (mem_req_valid),
    .mem_req_ready (mem_req_ready),
    .mem_rsp_valid (mem_rsp_valid),
    .mem_rsp_ready (mem_rsp_ready),
    .rsp_fire      (rsp_fire),
    .done_valid    (done_valid),
    .done_ready    (done_ready)
  );

  regmgr_datapath u_datapath (
    .clk           (clk),
    .rst           (rst),
    .cmd_fire      (cmd_fire),
    .rsp_fire      (rsp_fire),
    .cmd_op        (cmd_op),
    .cmd_reg_num   (cmd_reg_num),
    .cmd_is_ptr    (cmd_is_ptr),
    .cmd_step      (cmd_step),
    .cmd_data      (cmd_data),
    .base_addr     (base_addr),
    .mem_rsp_data  (mem_rsp_data),
    .mem_req_write (mem_req_write),
    .mem_req_addr  (mem_req_addr),
    .mem_req_data  (mem_req_data),
    .done_data     (done_data)
  );

endmodule

//--- verilog/regmgr_datapath.sv
`timescale 1ns/1ps

// value and pointer registers
// request address / write data forming, post step
module regmgr_datapath (
  input  logic                        clk,
  input  logic                        rst,

  // strobes from the controller
  input  logic                        cmd_fire,
  input  logic                        rsp_fire,

  // command fields
  input  regmgr_op_pkg::reg_op_t      cmd_op,
  input  regmgr_cfg_pkg::reg_num_t    cmd_reg_num,
  input  logic                        cmd_is_ptr,
  input  regmgr_op_pkg::step_t        cmd_step,
  input  regmgr_cfg_pkg::word_t       cmd_data,
  input  regmgr_cfg_pkg::addr_t       base_addr,

  // memory side
  input  regmgr_cfg_pkg::word_t       mem_rsp_data,
  output logic                        mem_req_write,
  output regmgr_cfg_pkg::addr_t       mem_req_addr,
  output regmgr_cfg_pkg::word_t       mem_req_data,

  // result
  output regmgr_cfg_pkg::word_t       done_data
);

  import regmgr_cfg_pkg::*;
  import regmgr_op_pkg::*;

  // architectural registers
  word_t   value_q;
  word_t   ptr_q;

  // opcode of the command in flight
  // selects which registers a response loads
  reg_op_t op_q;

  // request payload, held while the request waits
  logic    req_write_q;
  addr_t   req_addr_q;
  word_t   req_data_q;

  // combinational forming from the command fields
  word_t   wr_src;
  word_t   wr_data;
  addr_t   req_addr;

  // post step of the write source, wraps both ways
  function automatic word_t step_word(input word_t src, input step_t step);
    word_t res;
    case (step)
      STEP_INC: res = src + word_t'(1);
      STEP_DEC: res = src - word_t'(1);
      default:  res = src;
    endcase
    return res;
  endfunction

  // write source
  // pointer reg only for OP_WRITE with cmd_is_ptr
  assign wr_src = (cmd_op == OP_WRITE && cmd_is_ptr) ? ptr_q : value_q;

  // OP_WRITE_P stores the value reg unstepped
  assign wr_data = (cmd_op == OP_WRITE) ? step_word(wr_src, cmd_step) : wr_src;

  // pointer forms go through ptr_q, the rest through reg number
  // sum wraps at ADDR_W
  assign req_addr = (cmd_op == OP_READ_P || cmd_op == OP_WRITE_P)
                    ? base_addr + addr_t'(ptr_q)
                    : base_addr + addr_t'(cmd_reg_num);

  // control side: registers, opcode, write flag
  always_ff @(posedge clk) begin
    if (rst) begin
      value_q     <= '0;
      ptr_q       <= '0;
      op_q        <= OP_LOAD;
      req_write_q <= 1'b0;
    end else if (cmd_fire) begin
      op_q        <= cmd_op;
      req_write_q <= (cmd_op == OP_WRITE || cmd_op == OP_WRITE_P);
      // execution result straight into the value reg
      if (cmd_op == OP_LOAD) begin
        value_q <= cmd_data;
      end
    end else if (rsp_fire) begin
      case (op_q)
        // direct read fills both registers
        OP_READ: begin
          value_q <= mem_rsp_data;
          ptr_q   <= mem_rsp_data;
        end
        OP_READ_P: begin
          value_q <= mem_rsp_data;
        end
        // write responses carry nothing
        default: begin
        end
      endcase
    end
  end

  // request payload captured once per command
  always_ff @(posedge clk) begin
    if (cmd_fire) begin
      req_addr_q <= req_addr;
      req_data_q <= wr_data;
    end
  end

  assign mem_req_write = req_write_q;
  assign mem_req_addr  = req_addr_q;
  assign mem_req_data  = req_data_q;

  // value reg after the command
  assign done_data = value_q;

endmodule

//--- verilog/regmgr_ctrl.sv
`timescale 1ns/1ps

// sequences one register command at a time
// command accept -> memory request -> response -> done
module regmgr_ctrl (
  input  logic                     clk,
  input  logic                     rst,

  // command port
  input  logic                     cmd_valid,
  input  regmgr_op_pkg::reg_op_t   cmd_op,
  output logic                     cmd_ready,
  output logic                     cmd_fire,

  // memory request / response handshakes
  output logic                     mem_req_valid,
  input  logic                     mem_req_ready,
  input  logic                     mem_rsp_valid,
  output logic                     mem_rsp_ready,
  output logic                     rsp_fire,

  // done port
  output logic                     done_valid,
  input  logic                     done_ready
);

  import regmgr_op_pkg::*;

  ctrl_state_t state;
  ctrl_state_t state_nxt;

  // command needs a memory access
  logic cmd_is_mem;

  // handshake terms
  logic req_fire;
  logic done_fire;

  // only OP_LOAD stays off the memory bus
  assign cmd_is_mem = (cmd_op != OP_LOAD);

  // ready only while idle
  // a held request or result keeps new commands out
  assign cmd_ready = (state == S_IDLE);
  assign cmd_fire  = cmd_valid & cmd_ready;

  // request stays up until the memory takes it
  assign mem_req_valid = (state == S_REQ);
  assign req_fire      = mem_req_valid & mem_req_ready;

  // single outstanding request
  // any response seen in wait belongs to it
  assign mem_rsp_ready = (state == S_WAIT);
  assign rsp_fire      = mem_rsp_valid & mem_rsp_ready;

  // result held until the consumer takes it
  assign done_valid = (state == S_DONE);
  assign done_fire  = done_valid & done_ready;

  // next state
  always_comb begin
    state_nxt = state;
    case (state)
      S_IDLE: begin
        if (cmd_fire) begin
          // load finishes at T+1
          // memory commands raise the request at T+1
          if (cmd_is_mem) begin
            state_nxt = S_REQ;
          end else begin
            state_nxt = S_DONE;
          end
        end
      end

      S_REQ: begin
        // request accepted, wait for its response
        if (req_fire) begin
          state_nxt = S_WAIT;
        end
      end

      S_WAIT: begin
        // reads and writes both get one response
        // datapath loads registers on the same edge
        if (rsp_fire) begin
          state_nxt = S_DONE;
        end
      end

      S_DONE: begin
        if (done_fire) begin
          state_nxt = S_IDLE;
        end
      end

      default: begin
        state_nxt = S_IDLE;
      end
    endcase
  end

  // state register
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= S_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

endmodule

//--- verilog/regmgr_op_pkg.sv
// command opcodes, post-step modes and controller states
package regmgr_op_pkg;

  // register commands
  typedef enum logic [2:0] {
    OP_LOAD    = 3'd0,  // value reg takes the execution result
    OP_READ    = 3'd1,  // read register at base + reg number
    OP_READ_P  = 3'd2,  // read through the pointer register
    OP_WRITE   = 3'd3,  // write back, optional post step
    OP_WRITE_P = 3'd4   // write value reg through the pointer
  } reg_op_t;

  // post-increment / post-decrement on write back
  // STEP_NONE writes the source as is
  typedef enum logic [1:0] {
    STEP_NONE = 2'b00,
    STEP_INC  = 2'b01,
    STEP_DEC  = 2'b10
  } step_t;

  // controller FSM
  // load goes idle -> done
  // memory commands go idle -> req -> wait -> done
  typedef enum logic [1:0] {
    S_IDLE = 2'd0,  // ready for a command
    S_REQ  = 2'd1,  // memory request valid
    S_WAIT = 2'd2,  // waiting on the response
    S_DONE = 2'd3   // result held on the done port
  } ctrl_state_t;

endpackage

//--- verilog/regmgr_cfg_pkg.sv
// widths shared by the controller, datapath and top level
// registers live in data memory at base_addr + register number
package regmgr_cfg_pkg;

  // data word, same for registers and memory
  localparam int WORD_W = 16;

  // memory address width
  // addresses wrap modulo 2**ADDR_W
  localparam int ADDR_W = 16;

  // register number width, 16 general registers
  localparam int REG_NUM_W = 4;

  // register contents and memory data
  typedef logic [WORD_W-1:0] word_t;

  // memory address
  // also the sum of base and register number
  typedef logic [ADDR_W-1:0] addr_t;

  // general register index
  typedef logic [REG_NUM_W-1:0] reg_num_t;

  // note the pointer register holds a word_t
  // and is added to the base as an address, so the
  // two widths are kept equal here

  // register number is zero-extended before the add
  // a carry out of ADDR_W is dropped

  // value register
  // loaded by OP_LOAD, OP_READ and OP_READ_P
  // returned on done_data after every command

  // pointer register
  // loaded only by OP_READ, together with the value register
  // addresses OP_READ_P and OP_WRITE_P

endpackage
